// File: rtl/mem_pkg.sv
package mem_pkg;

    localparam int WORD_SIZE        = 32;
    localparam int LINE_BYTES       = 16;
    localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES);

    // byte address, wraps above the memory capacity
    typedef logic [WORD_SIZE-1:0] addr_t;

    // store data, the low bytes carry byte and halfword stores
    typedef logic [WORD_SIZE-1:0] word_t;

    // byte i of a line sits in bits 8i+7:8i (little-endian)
    typedef logic [LINE_BYTES*8-1:0] line_t;

    // byte position inside a line
    typedef logic [LINE_OFFSET_BITS-1:0] offset_t;

    typedef enum logic [1:0] {
        MEM_BYTE = 2'b00,
        MEM_HALF = 2'b01,
        MEM_WORD = 2'b10,
        MEM_RSVD = 2'b11  // stores nothing
    } memop_size_e;

endpackage

// File: rtl/bank_req_if.sv
interface bank_req_if #(
    parameter int ROW_BITS = 6
);
    import mem_pkg::*;

    logic                rd;         // load strobe for this bank
    logic [ROW_BITS-1:0] rd_row;
    logic                wr;         // store strobe for this bank
    logic [ROW_BITS-1:0] wr_row;
    offset_t             wr_offset;  // first byte written inside the line
    memop_size_e         wr_size;
    word_t               wr_data;

    modport dispatch (
        output rd,
        output rd_row,
        output wr,
        output wr_row,
        output wr_offset,
        output wr_size,
        output wr_data
    );

    modport bank (
        input rd,
        input rd_row,
        input wr,
        input wr_row,
        input wr_offset,
        input wr_size,
        input wr_data
    );

endinterface

// File: rtl/mem_req_dispatch.sv
module mem_req_dispatch #(
    parameter int NUM_BANKS      = 4,
    parameter int LINES_PER_BANK = 64
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 rd_i,
    input  mem_pkg::addr_t       rd_addr_i,
    input  logic                 wr_i,
    input  mem_pkg::addr_t       wr_addr_i,
    input  mem_pkg::memop_size_e wr_size_i,
    input  mem_pkg::word_t       wr_data_i,
    bank_req_if.dispatch         bank_o [NUM_BANKS]
);
    import mem_pkg::*;

    localparam int BANK_BITS = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
    localparam int ROW_BITS  = $clog2(LINES_PER_BANK);

    addr_t                rd_line_idx;
    addr_t                wr_line_idx;
    logic [BANK_BITS-1:0] rd_bank;
    logic [BANK_BITS-1:0] wr_bank;
    logic [ROW_BITS-1:0]  rd_row;
    logic [ROW_BITS-1:0]  wr_row;
    offset_t              wr_offset;

    assign rd_line_idx = rd_addr_i >> LINE_OFFSET_BITS;
    assign wr_line_idx = wr_addr_i >> LINE_OFFSET_BITS;

    // low line-index bits pick the bank, the next ones the row
    assign rd_bank = BANK_BITS'(rd_line_idx % NUM_BANKS);
    assign wr_bank = BANK_BITS'(wr_line_idx % NUM_BANKS);
    assign rd_row  = ROW_BITS'(rd_line_idx / NUM_BANKS);  // upper bits dropped, addresses wrap
    assign wr_row  = ROW_BITS'(wr_line_idx / NUM_BANKS);

    assign wr_offset = wr_addr_i[LINE_OFFSET_BITS-1:0];

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign bank_o[b].rd        = rd_i && (rd_bank == BANK_BITS'(b));
        assign bank_o[b].rd_row    = rd_row;
        assign bank_o[b].wr        = wr_i && (wr_bank == BANK_BITS'(b));
        assign bank_o[b].wr_row    = wr_row;
        assign bank_o[b].wr_offset = wr_offset;
        assign bank_o[b].wr_size   = wr_size_i;
        assign bank_o[b].wr_data   = wr_data_i;
    end

    // the core only ever asks for whole lines
    a_rd_line_aligned : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        rd_i |-> (rd_addr_i[LINE_OFFSET_BITS-1:0] == '0)
    );

    // halfwords on even bytes, words on multiples of four
    a_wr_natural_align : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        wr_i |-> !((wr_size_i == MEM_HALF && wr_addr_i[0]) ||
                   (wr_size_i == MEM_WORD && wr_addr_i[1:0] != 2'b00))
    );

endmodule

// File: rtl/mem_bank.sv
module mem_bank #(
    parameter int LINES_PER_BANK = 64,
    parameter int MEM_LATENCY    = 10
) (
    input  logic           clk_i,
    input  logic           arst_n_i,
    bank_req_if.bank       req_i,
    output logic           done_o,
    output mem_pkg::line_t line_o
);
    import mem_pkg::*;

    // one stage is the storage read, the collector adds the last register
    localparam int STAGES = MEM_LATENCY - 1;

    logic [7:0]            mem_q [LINES_PER_BANK][LINE_BYTES];  // byte lanes, no reset

    logic [LINE_BYTES-1:0] wr_be;
    line_t                 wr_line;
    line_t                 rd_line;

    logic [STAGES-1:0]     vld_q;
    line_t                 line_q [STAGES];

    // place the store data on every lane it could land on, then enable
    // only the lanes the access covers
    always_comb begin
        case (req_i.wr_size)
            MEM_BYTE: begin
                wr_be   = LINE_BYTES'(1) << req_i.wr_offset;
                wr_line = {(LINE_BYTES){req_i.wr_data[7:0]}};
            end
            MEM_HALF: begin
                wr_be   = LINE_BYTES'(3) << req_i.wr_offset;
                wr_line = {(LINE_BYTES/2){req_i.wr_data[15:0]}};
            end
            MEM_WORD: begin
                wr_be   = LINE_BYTES'(15) << req_i.wr_offset;
                wr_line = {(LINE_BYTES/4){req_i.wr_data}};
            end
            default: begin
                wr_be   = '0;  // reserved code writes nothing
                wr_line = '0;
            end
        endcase
        if (!req_i.wr) begin
            wr_be = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < LINE_BYTES; i++) begin
            if (wr_be[i]) begin
                mem_q[req_i.wr_row][i] <= wr_line[8*i +: 8];
            end
        end
    end

    // read sees storage before a store at the same edge
    always_comb begin
        for (int i = 0; i < LINE_BYTES; i++) begin
            rd_line[8*i +: 8] = mem_q[req_i.rd_row][i];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            vld_q <= '0;  // drops loads in flight
        end else begin
            vld_q[0] <= req_i.rd;
            for (int s = 1; s < STAGES; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_i.rd) begin
            line_q[0] <= rd_line;  // captured at issue
        end
        for (int s = 1; s < STAGES; s++) begin
            line_q[s] <= line_q[s-1];
        end
    end

    assign done_o = vld_q[STAGES-1];
    assign line_o = line_q[STAGES-1];

    // the core never issues the reserved size
    a_no_rsvd_store : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        req_i.wr |-> (req_i.wr_size != MEM_RSVD)
    );

endmodule

// File: rtl/mem_rsp_collect.sv
module mem_rsp_collect #(
    parameter int NUM_BANKS = 4
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic [NUM_BANKS-1:0] done_i,
    input  mem_pkg::line_t       line_i [NUM_BANKS],
    output logic                 rsp_valid_o,
    output mem_pkg::line_t       rsp_line_o
);
    import mem_pkg::*;

    line_t sel_line;
    logic  any_done;

    assign any_done = |done_i;

    // at most one bank finishes per cycle
    always_comb begin
        sel_line = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            if (done_i[b]) begin
                sel_line = line_i[b];
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= any_done;  // one-cycle pulse per load
        end
    end

    always_ff @(posedge clk_i) begin
        if (any_done) begin
            rsp_line_o <= sel_line;
        end
    end

    // banks share one latency and loads issue one per cycle, so done bits
    // from different banks never line up
    a_one_done : assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        $onehot0(done_i)
    );

endmodule

// File: rtl/line_mem.sv
module line_mem #(
    parameter int NUM_BANKS      = 4,
    parameter int LINES_PER_BANK = 64,
    parameter int MEM_LATENCY    = 10
) (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  logic                 rd_i,
    input  mem_pkg::addr_t       rd_addr_i,
    input  logic                 wr_i,
    input  mem_pkg::addr_t       wr_addr_i,
    input  mem_pkg::memop_size_e wr_size_i,
    input  mem_pkg::word_t       wr_data_i,
    output logic                 rsp_valid_o,
    output mem_pkg::line_t       rsp_line_o
);
    import mem_pkg::*;

    localparam int ROW_BITS = $clog2(LINES_PER_BANK);

    bank_req_if #(.ROW_BITS(ROW_BITS)) bank_req [NUM_BANKS] ();

    logic [NUM_BANKS-1:0] bank_done;
    line_t                bank_line [NUM_BANKS];

    mem_req_dispatch #(
        .NUM_BANKS      (NUM_BANKS),
        .LINES_PER_BANK (LINES_PER_BANK)
    ) u_dispatch (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .rd_i      (rd_i),
        .rd_addr_i (rd_addr_i),
        .wr_i      (wr_i),
        .wr_addr_i (wr_addr_i),
        .wr_size_i (wr_size_i),
        .wr_data_i (wr_data_i),
        .bank_o    (bank_req)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        mem_bank #(
            .LINES_PER_BANK (LINES_PER_BANK),
            .MEM_LATENCY    (MEM_LATENCY)
        ) u_bank (
            .clk_i    (clk_i),
            .arst_n_i (arst_n_i),
            .req_i    (bank_req[b]),
            .done_o   (bank_done[b]),
            .line_o   (bank_line[b])
        );
    end

    mem_rsp_collect #(
        .NUM_BANKS (NUM_BANKS)
    ) u_collect (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .done_i      (bank_done),
        .line_i      (bank_line),
        .rsp_valid_o (rsp_valid_o),
        .rsp_line_o  (rsp_line_o)
    );

endmodule

// File: tb/tb_line_mem.sv
module tb_line_mem;
    import mem_pkg::*;

    localparam int NUM_BANKS      = 4;
    localparam int LINES_PER_BANK = 64;
    localparam int MEM_LATENCY    = 10;
    localparam int CAP_BYTES      = NUM_BANKS * LINES_PER_BANK * LINE_BYTES;
    localparam int DRIVE_DLY      = 10;
    localparam int TIMEOUT        = 200;

    logic        clk_i;
    logic        arst_n_i;
    logic        rd_i;
    addr_t       rd_addr_i;
    logic        wr_i;
    addr_t       wr_addr_i;
    memop_size_e wr_size_i;
    word_t       wr_data_i;
    logic        rsp_valid_o;
    line_t       rsp_line_o;

    logic [7:0]  model_mem [CAP_BYTES];  // reference bytes folded by capacity
    line_t       rsp_q [$];
    int          rsp_cyc_q [$];
    int          cyc;
    int          errors;
    int          timeouts;

    line_mem u_line_mem (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .rd_i        (rd_i),
        .rd_addr_i   (rd_addr_i),
        .wr_i        (wr_i),
        .wr_addr_i   (wr_addr_i),
        .wr_size_i   (wr_size_i),
        .wr_data_i   (wr_data_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_line_o  (rsp_line_o)
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) cyc++;

    // response monitor samples at the falling edge where outputs are stable
    always @(negedge clk_i) begin
        if (rsp_valid_o === 1'b1) begin
            rsp_q.push_back(rsp_line_o);
            rsp_cyc_q.push_back(cyc);
        end
    end

    function automatic line_t model_line(input addr_t a);
        line_t       l;
        int unsigned base;
        base = (a % CAP_BYTES) & ~(LINE_BYTES - 1);
        for (int i = 0; i < LINE_BYTES; i++) begin
            l[8*i +: 8] = model_mem[base + i];  // little-endian
        end
        return l;
    endfunction

    task automatic put_store(input addr_t a, input memop_size_e sz, input word_t d);
        int n;
        n = (sz == MEM_BYTE) ? 1 : (sz == MEM_HALF) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            model_mem[(a + k) % CAP_BYTES] = d[8*k +: 8];
        end
        wr_i      = 1'b1;
        wr_addr_i = a;
        wr_size_i = sz;
        wr_data_i = d;
    endtask

    task automatic put_load(input addr_t a);
        rd_i      = 1'b1;
        rd_addr_i = a;
    endtask

    task automatic step();
        @(posedge clk_i);
        #DRIVE_DLY;
        rd_i = 1'b0;
        wr_i = 1'b0;
    endtask

    task automatic do_store(input addr_t a, input memop_size_e sz, input word_t d);
        put_store(a, sz, d);
        step();
    endtask

    task automatic write_line(input addr_t base);
        for (int w = 0; w < LINE_BYTES / 4; w++) begin
            do_store(base + 4 * w, MEM_WORD, $urandom);
        end
    endtask

    task automatic wait_rsp(input string name, input int n);
        int t;
        t = 0;
        while (rsp_q.size() < n && t < TIMEOUT) begin
            step();
            t++;
        end
        if (rsp_q.size() < n) begin
            $display("%s: timed out waiting for %0d responses, got %0d", name, n, rsp_q.size());
            timeouts++;
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic test_word_load();
        line_t exp;
        int    issue_cyc;
        rsp_q.delete();
        rsp_cyc_q.delete();
        write_line(32'h100);
        exp = model_line(32'h100);
        put_load(32'h100);
        issue_cyc = cyc;
        step();
        wait_rsp("word_load", 1);
        repeat (3) step();
        if (rsp_q.size() != 1) begin
            $display("FAIL word_load expected 1 response actual %0d", rsp_q.size());
            errors++;
        end
        if (rsp_q.size() > 0) begin
            if (rsp_cyc_q[0] != issue_cyc + MEM_LATENCY) begin
                $display("FAIL word_load expected latency %0d actual %0d",
                         MEM_LATENCY, rsp_cyc_q[0] - issue_cyc);
                errors++;
            end
            check_line("word_load", exp, rsp_q[0]);
        end
    endtask

    task automatic test_merge();
        rsp_q.delete();
        rsp_cyc_q.delete();
        write_line(32'h200);
        do_store(32'h201, MEM_BYTE, 32'hffff_ff5a);  // upper data bits must not land
        do_store(32'h206, MEM_BYTE, 32'h0000_00c3);
        do_store(32'h20f, MEM_BYTE, 32'h1234_5677);
        do_store(32'h202, MEM_HALF, 32'hdead_beef);
        do_store(32'h208, MEM_HALF, 32'h0000_a55a);
        do_store(32'h20c, MEM_HALF, 32'h7777_0110);
        put_load(32'h200);
        step();
        wait_rsp("merge", 1);
        if (rsp_q.size() > 0) check_line("merge", model_line(32'h200), rsp_q[0]);
    endtask

    task automatic test_pipelined();
        line_t exp_q [$];
        rsp_q.delete();
        rsp_cyc_q.delete();
        for (int l = 0; l < 2 * NUM_BANKS; l++) write_line(32'h300 + 16 * l);
        for (int l = 0; l < 2 * NUM_BANKS; l++) begin
            exp_q.push_back(model_line(32'h300 + 16 * l));
            put_load(32'h300 + 16 * l);
            step();
        end
        wait_rsp("pipelined", exp_q.size());
        for (int i = 0; i < exp_q.size() && i < rsp_q.size(); i++) begin
            check_line("pipelined", exp_q[i], rsp_q[i]);
            if (rsp_cyc_q[i] != rsp_cyc_q[0] + i) begin
                $display("FAIL pipelined expected cycle %0d actual %0d",
                         rsp_cyc_q[0] + i, rsp_cyc_q[i]);
                errors++;
            end
        end
    endtask

    task automatic test_same_cycle();
        line_t old_line;
        rsp_q.delete();
        rsp_cyc_q.delete();
        write_line(32'h400);
        old_line = model_line(32'h400);  // read sees storage before the store
        put_load(32'h400);
        put_store(32'h404, MEM_WORD, 32'hcafe_f00d);
        step();
        put_load(32'h400);
        step();
        wait_rsp("same_cycle", 2);
        if (rsp_q.size() > 1) begin
            check_line("same_cycle_old", old_line, rsp_q[0]);
            check_line("same_cycle_new", model_line(32'h400), rsp_q[1]);
        end
    endtask

    task automatic test_reset_flight();
        rsp_q.delete();
        rsp_cyc_q.delete();
        write_line(32'h500);
        for (int i = 0; i < 3; i++) begin
            put_load(32'h500);
            step();
        end
        step();
        arst_n_i = 1'b0;
        repeat (2) step();
        arst_n_i = 1'b1;
        repeat (MEM_LATENCY + 4) step();
        if (rsp_q.size() != 0) begin
            $display("reset_flight: %0d responses appeared for loads dropped by reset",
                     rsp_q.size());
            errors++;
        end
        put_load(32'h500);
        step();
        wait_rsp("reset_flight", 1);
        if (rsp_q.size() > 0) check_line("reset_flight", model_line(32'h500), rsp_q[0]);
    endtask

    task automatic test_random();
        line_t       exp_q [$];
        addr_t       a;
        memop_size_e sz;
        // fill every byte first with a pattern that follows the word address
        for (int unsigned w = 0; w < CAP_BYTES; w += 4) begin
            do_store(w, MEM_WORD, {~w[15:0], w[15:0]});
        end
        rsp_q.delete();
        rsp_cyc_q.delete();
        for (int i = 0; i < 200; i++) begin
            if ($urandom_range(1, 0) == 1) begin
                a = $urandom & ~32'hf;  // full 32-bit range that wraps
                exp_q.push_back(model_line(a));
                put_load(a);
            end
            sz = memop_size_e'($urandom_range(2, 0));
            a  = $urandom;
            if (sz == MEM_HALF) a[0] = 1'b0;
            if (sz == MEM_WORD) a[1:0] = 2'b00;
            put_store(a, sz, $urandom);
            step();
        end
        wait_rsp("random", exp_q.size());
        for (int i = 0; i < exp_q.size() && i < rsp_q.size(); i++) begin
            check_line("random", exp_q[i], rsp_q[i]);
        end
    endtask

    initial begin
        void'($urandom(92371));
        clk_i     = 1'b0;
        arst_n_i  = 1'b0;
        rd_i      = 1'b0;
        rd_addr_i = '0;
        wr_i      = 1'b0;
        wr_addr_i = '0;
        wr_size_i = MEM_BYTE;
        wr_data_i = '0;
        cyc       = 0;
        errors    = 0;
        timeouts  = 0;
        repeat (10) @(posedge clk_i);
        #DRIVE_DLY;
        arst_n_i = 1'b1;
        step();
        test_word_load();
        test_merge();
        test_pipelined();
        test_same_cycle();
        test_reset_flight();
        test_random();
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
rtl/mem_pkg.sv
rtl/bank_req_if.sv
rtl/mem_req_dispatch.sv
rtl/mem_bank.sv
rtl/mem_rsp_collect.sv
rtl/line_mem.sv
tb/tb_line_mem.sv
